// File: source/fetch_pkg.sv
package fetch_pkg;

   // Address and instruction width.
   localparam int XLEN = 32;

   // One cache line holds four instruction words.
   localparam int LINE_BITS = 128;
   localparam int ICACHE_LINES = 16;

   localparam int OFFSET_BITS = 4;
   localparam int INDEX_BITS = 4;
   localparam int TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   // Line fill, same shape as what main memory returns.
   typedef struct packed {
      logic [XLEN-1:0]      addr;
      logic [LINE_BITS-1:0] data;
   } fetch_line_t;

   // Instruction handed to the pre-decoder.
   typedef struct packed {
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] instr;
   } fetch_instr_t;

   // Cache controller FSM states.
   typedef enum logic [1:0] {
      IDLE        = 2'd0,
      LOOKUP      = 2'd1,
      MEM_READ    = 2'd2,
      CACHE_WRITE = 2'd3
   } ctrl_state_t;

endpackage

// File: source/fetch_pc_stage.sv
`timescale 1ns/1ps

module fetch_pc_stage (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       stall_i,
   input  logic                       redirect_i,
   input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
   input  logic                       advance_i,
   output logic [fetch_pkg::XLEN-1:0] pc_o
);

   logic [fetch_pkg::XLEN-1:0] pc_q;

   // A redirect wins over everything else, a stall included.
   // Otherwise the pc steps one word for every delivered instruction.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         pc_q <= fetch_pkg::RESET_PC;
      end else if (redirect_i) begin
         pc_q <= redirect_pc_i;
      end else if (advance_i && !stall_i) begin
         pc_q <= pc_q + fetch_pkg::XLEN'(4);
      end
   end

   assign pc_o = pc_q;

   // Redirect targets come from outside, so alignment is checked here.
   pc_word_aligned_a : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      pc_o[1:0] == 2'b00
   );

endmodule

// File: source/icache_array.sv
`timescale 1ns/1ps

module icache_array (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic [fetch_pkg::XLEN-1:0] pc_i,
   input  logic                       line_we_i,
   input  fetch_pkg::fetch_line_t     line_i,
   output logic                       hit_o,
   output logic [fetch_pkg::XLEN-1:0] word_o
);

   logic [fetch_pkg::TAG_BITS-1:0]   tag_mem  [fetch_pkg::ICACHE_LINES];
   logic [fetch_pkg::LINE_BITS-1:0]  data_mem [fetch_pkg::ICACHE_LINES];
   logic [fetch_pkg::ICACHE_LINES-1:0] valid_q;

   logic [fetch_pkg::INDEX_BITS-1:0] rd_index;
   logic [fetch_pkg::TAG_BITS-1:0]   rd_tag;
   logic [fetch_pkg::LINE_BITS-1:0]  rd_line;
   logic [1:0]                       rd_word;

   logic [fetch_pkg::INDEX_BITS-1:0] wr_index;
   logic [fetch_pkg::TAG_BITS-1:0]   wr_tag;

   // Address split: tag, index, then byte offset within the line.
   assign rd_index = pc_i[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
   assign rd_tag   = pc_i[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
   assign rd_word  = pc_i[fetch_pkg::OFFSET_BITS-1:2];

   assign wr_index = line_i.addr[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
   assign wr_tag   = line_i.addr[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];

   // Lookup is purely combinational so the controller sees the hit in LOOKUP.
   assign rd_line = data_mem[rd_index];
   assign hit_o   = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
   assign word_o  = rd_line[rd_word * fetch_pkg::XLEN +: fetch_pkg::XLEN];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_q <= '0;
      end else if (line_we_i) begin
         valid_q[wr_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (line_we_i) begin
         tag_mem[wr_index]  <= wr_tag;
         data_mem[wr_index] <= line_i.data;
      end
   end

   // The controller must hand over line-aligned fill addresses.
   line_addr_aligned_a : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      line_we_i |-> (line_i.addr[fetch_pkg::OFFSET_BITS-1:0] == '0)
   );

endmodule

// File: source/icache_controller.sv
`timescale 1ns/1ps

module icache_controller (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            stall_i,
   input  logic [fetch_pkg::XLEN-1:0]      pc_i,
   input  logic                            hit_i,
   input  logic [fetch_pkg::XLEN-1:0]      word_i,
   input  logic                            mem_avail_i,
   input  logic                            mem_ready_i,
   input  logic [fetch_pkg::LINE_BITS-1:0] mem_line_i,
   output logic                            mem_req_o,
   output logic [fetch_pkg::XLEN-1:0]      mem_addr_o,
   output logic                            line_we_o,
   output fetch_pkg::fetch_line_t          line_o,
   output fetch_pkg::fetch_instr_t         instr_o,
   output logic                            instr_valid_o
);

   fetch_pkg::ctrl_state_t state_q;
   fetch_pkg::ctrl_state_t state_d;

   logic [fetch_pkg::XLEN-1:0]      miss_pc_q;
   logic [fetch_pkg::LINE_BITS-1:0] line_q;

   logic                            start_miss;
   logic [fetch_pkg::XLEN-1:0]      pc_line_addr;
   logic [fetch_pkg::XLEN-1:0]      miss_line_addr;
   logic [fetch_pkg::XLEN-1:0]      miss_word;

   assign pc_line_addr   = {pc_i[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                            {fetch_pkg::OFFSET_BITS{1'b0}}};
   assign miss_line_addr = {miss_pc_q[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                            {fetch_pkg::OFFSET_BITS{1'b0}}};

   // A miss only goes out while memory says it can take a request.
   assign start_miss = (state_q == fetch_pkg::LOOKUP) && !stall_i && !hit_i && mem_avail_i;

   // Word of the refilled line that the missed pc points at.
   assign miss_word = line_q[miss_pc_q[fetch_pkg::OFFSET_BITS-1:2] * fetch_pkg::XLEN
                             +: fetch_pkg::XLEN];

   always_comb begin
      state_d       = state_q;
      instr_o       = '0;
      instr_valid_o = 1'b0;

      case (state_q)
         fetch_pkg::IDLE: begin
            if (!stall_i) begin
               state_d = fetch_pkg::LOOKUP;
            end
         end

         fetch_pkg::LOOKUP: begin
            if (!stall_i) begin
               if (hit_i) begin
                  instr_o.pc    = pc_i;
                  instr_o.instr = word_i;
                  instr_valid_o = 1'b1;
                  state_d       = fetch_pkg::IDLE;
               end else if (mem_avail_i) begin
                  state_d = fetch_pkg::MEM_READ;
               end
            end
         end

         // The refill runs to completion regardless of stall.
         fetch_pkg::MEM_READ: begin
            if (mem_ready_i) begin
               state_d = fetch_pkg::CACHE_WRITE;
            end
         end

         fetch_pkg::CACHE_WRITE: begin
            if (!stall_i) begin
               // A redirect during the refill moved the pc, so the word is stale.
               if (pc_i == miss_pc_q) begin
                  instr_o.pc    = miss_pc_q;
                  instr_o.instr = miss_word;
                  instr_valid_o = 1'b1;
               end
               state_d = fetch_pkg::IDLE;
            end
         end

         default: begin
            state_d = fetch_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= fetch_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_miss) begin
         miss_pc_q <= pc_i;
      end
      if (line_we_o) begin
         line_q <= mem_line_i;
      end
   end

   assign mem_req_o  = start_miss || ((state_q == fetch_pkg::MEM_READ) && !mem_ready_i);
   assign mem_addr_o = (state_q == fetch_pkg::MEM_READ) ? miss_line_addr : pc_line_addr;

   assign line_we_o   = (state_q == fetch_pkg::MEM_READ) && mem_ready_i;
   assign line_o.addr = miss_line_addr;
   assign line_o.data = mem_line_i;

   no_req_in_idle_a : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      (state_q == fetch_pkg::IDLE) |-> !mem_req_o
   );

   // Delivery and line fill belong to different states.
   no_deliver_on_fill_a : assert property (
      @(posedge clk_i) disable iff (!rst_i)
      !(instr_valid_o && line_we_o)
   );

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            stall_i,
   input  logic                            redirect_i,
   input  logic [fetch_pkg::XLEN-1:0]      redirect_pc_i,
   input  logic                            mem_avail_i,
   input  logic                            mem_ready_i,
   input  logic [fetch_pkg::LINE_BITS-1:0] mem_line_i,
   output logic                            mem_req_o,
   output logic [fetch_pkg::XLEN-1:0]      mem_addr_o,
   output fetch_pkg::fetch_instr_t         instr_o,
   output logic                            instr_valid_o
);

   logic [fetch_pkg::XLEN-1:0] pc;
   logic                       hit;
   logic [fetch_pkg::XLEN-1:0] word;
   logic                       line_we;
   fetch_pkg::fetch_line_t     line;

   // Each delivered instruction also steps the pc.
   fetch_pc_stage u_pc_stage (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .stall_i       (stall_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .advance_i     (instr_valid_o),
      .pc_o          (pc)
   );

   icache_controller u_controller (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .stall_i       (stall_i),
      .pc_i          (pc),
      .hit_i         (hit),
      .word_i        (word),
      .mem_avail_i   (mem_avail_i),
      .mem_ready_i   (mem_ready_i),
      .mem_line_i    (mem_line_i),
      .mem_req_o     (mem_req_o),
      .mem_addr_o    (mem_addr_o),
      .line_we_o     (line_we),
      .line_o        (line),
      .instr_o       (instr_o),
      .instr_valid_o (instr_valid_o)
   );

   icache_array u_array (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .pc_i      (pc),
      .line_we_i (line_we),
      .line_i    (line),
      .hit_o     (hit),
      .word_o    (word)
   );

endmodule

// File: bench/main_memory_model.sv
`timescale 1ns/1ps

module main_memory_model #(
   parameter int DRIVE_DELAY = 5
) (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            mem_req_i,
   input  logic [fetch_pkg::XLEN-1:0]      mem_addr_i,
   input  logic [3:0]                      latency_i,
   output logic                            mem_ready_o,
   output logic [fetch_pkg::LINE_BITS-1:0] mem_line_o
);

   logic                       rst_seen;
   logic                       req_seen;
   logic [fetch_pkg::XLEN-1:0] addr_seen;
   logic [3:0]                 lat_seen;
   logic                       busy;
   logic [3:0]                 count;
   logic [fetch_pkg::XLEN-1:0] line_addr;

   // Every word holds its own byte address XOR 32'h5a5a_0000.
   function automatic logic [fetch_pkg::LINE_BITS-1:0] line_at(
      input logic [fetch_pkg::XLEN-1:0] addr
   );
      logic [fetch_pkg::LINE_BITS-1:0] line;
      logic [fetch_pkg::XLEN-1:0]      base;
      base = {addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS], {fetch_pkg::OFFSET_BITS{1'b0}}};
      for (int w = 0; w < 4; w++) begin
         line[w*fetch_pkg::XLEN +: fetch_pkg::XLEN] = (base + 4*w) ^ 32'h5a5a_0000;
      end
      return line;
   endfunction

   initial begin
      mem_ready_o = 1'b0;
      mem_line_o  = '0;
      busy        = 1'b0;
      count       = '0;
      line_addr   = '0;
      forever begin
         // The request is sampled mid-cycle and answered just after the next edge.
         @(negedge clk_i);
         rst_seen  = rst_i;
         req_seen  = mem_req_i;
         addr_seen = mem_addr_i;
         lat_seen  = latency_i;
         @(posedge clk_i);
         #DRIVE_DELAY;
         mem_ready_o = 1'b0;
         mem_line_o  = '0;
         if (!rst_seen) begin
            busy = 1'b0;
         end else if (busy) begin
            if (count <= 4'd1) begin
               mem_ready_o = 1'b1;
               mem_line_o  = line_at(line_addr);
               busy        = 1'b0;
            end else begin
               count = count - 4'd1;
            end
         end else if (req_seen) begin
            busy      = 1'b1;
            line_addr = addr_seen;
            count     = lat_seen;
         end
      end
   end

endmodule

// File: bench/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

   localparam int          CLK_PERIOD     = 100;
   localparam int          DRIVE_DELAY    = 5;
   localparam int          RESET_CYCLES   = 10;
   localparam int          NUM_DELIVERIES = 2000;
   localparam int          TIMEOUT_CYCLES = 40 * NUM_DELIVERIES;
   localparam logic [31:0] LFSR_SEED      = 32'hcab3;

   logic                            clk;
   logic                            rst;
   logic                            stall;
   logic                            redirect;
   logic [fetch_pkg::XLEN-1:0]      redirect_pc;
   logic                            mem_avail;
   logic                            mem_ready;
   logic [fetch_pkg::LINE_BITS-1:0] mem_line;
   logic [3:0]                      mem_latency;
   logic                            mem_req;
   logic [fetch_pkg::XLEN-1:0]      mem_addr;
   fetch_pkg::fetch_instr_t         instr;
   logic                            instr_valid;

   logic [31:0]                        lfsr_state;
   logic [fetch_pkg::XLEN-1:0]         exp_pc;
   logic [fetch_pkg::XLEN-1:0]         req_addr;
   logic                               req_prev;
   logic                               refill_pending;
   logic [fetch_pkg::TAG_BITS-1:0]     shadow_tag [fetch_pkg::ICACHE_LINES];
   logic [fetch_pkg::ICACHE_LINES-1:0] shadow_valid;
   int deliveries;
   int cycles;
   int refills;
   int evictions;
   int late_redirects;

   fetch_unit dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .stall_i       (stall),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .mem_avail_i   (mem_avail),
      .mem_ready_i   (mem_ready),
      .mem_line_i    (mem_line),
      .mem_req_o     (mem_req),
      .mem_addr_o    (mem_addr),
      .instr_o       (instr),
      .instr_valid_o (instr_valid)
   );

   main_memory_model #(.DRIVE_DELAY(DRIVE_DELAY)) u_memory (
      .clk_i       (clk),
      .rst_i       (rst),
      .mem_req_i   (mem_req),
      .mem_addr_i  (mem_addr),
      .latency_i   (mem_latency),
      .mem_ready_o (mem_ready),
      .mem_line_o  (mem_line)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Taps 32, 22, 2 and 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
   endtask

   function automatic logic [fetch_pkg::XLEN-1:0] line_of(input logic [fetch_pkg::XLEN-1:0] a);
      return {a[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS], {fetch_pkg::OFFSET_BITS{1'b0}}};
   endfunction

   function automatic int index_of(input logic [fetch_pkg::XLEN-1:0] a);
      return int'(a[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS]);
   endfunction

   function automatic logic [fetch_pkg::TAG_BITS-1:0] tag_of(input logic [fetch_pkg::XLEN-1:0] a);
      return a[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
   endfunction

   function automatic logic line_resident(input logic [fetch_pkg::XLEN-1:0] a);
      return shadow_valid[index_of(a)] && (shadow_tag[index_of(a)] == tag_of(a));
   endfunction

   task automatic report_mismatch(input string msg);
      $display("Mismatch at %0t: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "Fetch unit check failed.");
   endtask

   task automatic report_failure(input string msg);
      $display("Error at %0t: %s", $time, msg);
      $display("Result: FAILED");
      $fatal(1, "Fetch unit check failed.");
   endtask

   task automatic check_instr(input fetch_pkg::fetch_instr_t actual,
                              input fetch_pkg::fetch_instr_t expected, input string what);
      if (actual !== expected) begin
         report_mismatch($sformatf("%s: got pc %h instr %h, expected pc %h instr %h", what,
                                   actual.pc, actual.instr, expected.pc, expected.instr));
      end
   endtask

   task automatic check_addr(input logic [fetch_pkg::XLEN-1:0] actual,
                             input logic [fetch_pkg::XLEN-1:0] expected, input string what);
      if (actual !== expected) begin
         report_mismatch($sformatf("%s: got %h, expected %h", what, actual, expected));
      end
   endtask

   task automatic drive_random_inputs();
      logic [31:0] bits;
      draw_bits(3, bits);
      stall = (bits[2:0] == 3'd0);
      draw_bits(5, bits);
      // The first delivery must come from the reset address.
      redirect = (bits[4:0] == 5'd0) && (deliveries > 0);
      draw_bits(8, bits);
      redirect_pc = {22'd0, bits[7:0], 2'b00};
      draw_bits(2, bits);
      mem_avail = (bits[1:0] != 2'd0);
      draw_bits(3, bits);
      mem_latency = {1'b0, bits[2:0]} + 4'd1;
   endtask

   // Runs mid-cycle and mirrors what the next rising edge does to the pc.
   task automatic check_cycle();
      fetch_pkg::fetch_instr_t expected;
      if (stall && instr_valid) begin
         report_failure("an instruction was delivered while stall was high");
      end
      if (instr_valid) begin
         // A delivered word can only come from a line the model has seen refilled.
         if (!line_resident(exp_pc)) begin
            report_failure($sformatf("pc %h was delivered without a refill of its line",
                                     exp_pc));
         end
         expected.pc    = exp_pc;
         expected.instr = exp_pc ^ 32'h5a5a_0000;
         if (deliveries == 0) begin
            check_addr(instr.pc, fetch_pkg::RESET_PC, "first delivered pc");
         end
         check_instr(instr, expected, "delivered instruction");
         deliveries++;
      end
      if (mem_req && !req_prev) begin
         if (!mem_avail) begin
            report_failure("a memory request was raised while memory was not available");
         end
         check_addr(mem_addr, line_of(exp_pc), "memory request address");
         if (line_resident(mem_addr)) begin
            report_failure($sformatf("memory was asked for resident line %h", mem_addr));
         end
         req_addr       = mem_addr;
         refill_pending = 1'b1;
      end else if (mem_req) begin
         check_addr(mem_addr, req_addr, "held memory request address");
      end
      if (mem_ready) begin
         if (shadow_valid[index_of(req_addr)]) begin
            evictions++;
         end
         shadow_valid[index_of(req_addr)] = 1'b1;
         shadow_tag[index_of(req_addr)]   = tag_of(req_addr);
         refill_pending = 1'b0;
         refills++;
      end
      if (redirect && refill_pending) begin
         late_redirects++;
      end
      if (redirect) begin
         exp_pc = redirect_pc;
      end else if (instr_valid && !stall) begin
         exp_pc = exp_pc + fetch_pkg::XLEN'(4);
      end
      req_prev = mem_req;
   endtask

   always @(negedge clk) begin
      if (rst) begin
         check_cycle();
      end
   end

   initial begin
      rst            = 1'b0;
      stall          = 1'b0;
      redirect       = 1'b0;
      redirect_pc    = '0;
      mem_avail      = 1'b0;
      mem_latency    = 4'd1;
      lfsr_state     = LFSR_SEED;
      exp_pc         = fetch_pkg::RESET_PC;
      req_addr       = '0;
      req_prev       = 1'b0;
      refill_pending = 1'b0;
      shadow_valid   = '0;
      deliveries     = 0;
      cycles         = 0;
      refills        = 0;
      evictions      = 0;
      late_redirects = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b1;
      while ((deliveries < NUM_DELIVERIES) && (cycles < TIMEOUT_CYCLES)) begin
         @(posedge clk);
         #DRIVE_DELAY;
         drive_random_inputs();
         cycles++;
      end
      if (deliveries < NUM_DELIVERIES) begin
         $display("Timeout: the fetch stalled with %0d of %0d instructions after %0d cycles.",
                  deliveries, NUM_DELIVERIES, cycles);
         $display("Result: FAILED");
         $fatal(1, "Fetch unit timed out.");
      end else begin
         $display("%0d instructions, %0d refills, %0d evictions, %0d redirects during refill.",
                  deliveries, refills, evictions, late_redirects);
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: tb.f
source/fetch_pkg.sv
source/fetch_pc_stage.sv
source/icache_array.sv
source/icache_controller.sv
source/fetch_unit.sv
bench/main_memory_model.sv
bench/fetch_unit_tb.sv
